// ==== Bender.yml ====
package:
  name: switch_arbiter

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/switch_hdr_pkg.sv
      - rtl/switch_arb_pkg.sv
      - rtl/priority_decoder.sv
      - rtl/priority_arbiter.sv
      - rtl/packet_forwarder.sv
      - rtl/switch_arbiter_top.sv

  - target: test
    include_dirs:
      - rtl
    files:
      - verif/tb_switch_arbiter.sv

// ==== project.f ====
+incdir+rtl
rtl/switch_hdr_pkg.sv
rtl/switch_arb_pkg.sv
rtl/priority_decoder.sv
rtl/priority_arbiter.sv
rtl/packet_forwarder.sv
rtl/switch_arbiter_top.sv
verif/tb_switch_arbiter.sv

// ==== rtl/packet_forwarder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "switch_cfg.svh"

module packet_forwarder (
    input  wire                                            clk,
    input  wire                                            rst,
    input  wire switch_hdr_pkg::word_t [`SW_NUM_PORTS-1:0] data_in,
    input  wire [`SW_NUM_PORTS-1:0]                        ready,
    input  wire [`SW_NUM_PORTS-1:0]                        eop,
    input  wire switch_arb_pkg::port_idx_t                 select,
    input  wire                                            grant_valid,
    input  wire switch_hdr_pkg::dest_t [`SW_NUM_PORTS-1:0] des_port_out,
    output switch_hdr_pkg::word_t                          out_data,
    output logic                                           out_valid,
    output logic                                           out_last,
    output switch_hdr_pkg::dest_t                          out_dest
);

    switch_hdr_pkg::word_t sel_word;
    switch_hdr_pkg::dest_t sel_dest;
    logic                  sel_eop;
    logic                  beat;

    // Granted port mux.
    assign sel_word = data_in[select];
    assign sel_dest = des_port_out[select];
    assign sel_eop  = eop[select];

    assign beat = grant_valid && ready[select]; // Gaps on ready just skip a cycle.

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else begin
            out_valid <= beat;
            out_last  <= beat && sel_eop;
        end
    end

    always_ff @(posedge clk) begin
        if (beat) begin
            out_data <= sel_word;
            out_dest <= sel_dest;
        end
    end

    a_last_valid: assert property (
        @(posedge clk) disable iff (rst) out_last |-> out_valid
    ) else $error("packet_forwarder: out_last without out_valid");

endmodule

`default_nettype wire

// ==== rtl/priority_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "switch_cfg.svh"

module priority_arbiter (
    input  wire                                           clk,
    input  wire                                           rst,
    input  wire switch_hdr_pkg::prio_t [`SW_NUM_PORTS-1:0] priority_out,
    input  wire [`SW_NUM_PORTS-1:0]                       req_mask,
    input  wire                                           snap_valid,
    output switch_arb_pkg::port_idx_t                     select,
    output logic                                          grant_valid
);

    switch_arb_pkg::arb_state_t state;
    switch_arb_pkg::port_idx_t  rr_ptr;
    switch_arb_pkg::port_idx_t  pick;
    switch_hdr_pkg::prio_t      max_prio;

    // Highest priority among requesting ports.
    always_comb begin : find_max
        int i;
        max_prio = '0;
        for (i = 0; i < `SW_NUM_PORTS; i++) begin
            if (req_mask[i] && (priority_out[i] > max_prio)) begin
                max_prio = priority_out[i];
            end
        end
    end

    // First requester at max_prio when scanning up from the pointer.
    always_comb begin : find_winner
        int k;
        logic found;
        switch_arb_pkg::port_idx_t idx;
        found = 1'b0;
        pick  = rr_ptr;
        for (k = 0; k < `SW_NUM_PORTS; k++) begin
            idx = switch_arb_pkg::port_idx_t'(rr_ptr + k); // Wraps at 16.
            if (!found && req_mask[idx] && (priority_out[idx] == max_prio)) begin
                pick  = idx;
                found = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= switch_arb_pkg::ARB_IDLE;
            rr_ptr <= '0;
            select <= '0;
        end else begin
            case (state)
                switch_arb_pkg::ARB_IDLE: begin
                    if (snap_valid) begin
                        state <= switch_arb_pkg::ARB_PICK;
                    end
                end
                switch_arb_pkg::ARB_PICK: begin
                    if (snap_valid) begin
                        select <= pick;
                        state  <= switch_arb_pkg::ARB_GRANT;
                    end else begin
                        state <= switch_arb_pkg::ARB_IDLE;
                    end
                end
                switch_arb_pkg::ARB_GRANT: begin
                    // Move past the winner once the snapshot is released.
                    if (!snap_valid) begin
                        rr_ptr <= switch_arb_pkg::rr_next(select);
                        state  <= switch_arb_pkg::ARB_IDLE;
                    end
                end
                default: begin
                    state <= switch_arb_pkg::ARB_IDLE;
                end
            endcase
        end
    end

    assign grant_valid = (state == switch_arb_pkg::ARB_GRANT) && snap_valid;

    a_select_stable: assert property (
        @(posedge clk) disable iff (rst) grant_valid ##1 grant_valid |-> $stable(select)
    ) else $error("priority_arbiter: select changed during grant");

    // Winner must come from the captured ready set.
    a_select_requested: assert property (
        @(posedge clk) disable iff (rst) grant_valid |-> req_mask[select]
    ) else $error("priority_arbiter: granted port was not requesting");

endmodule

`default_nettype wire

// ==== rtl/priority_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "switch_cfg.svh"

module priority_decoder (
    input  wire                                                clk,
    input  wire                                                rst,
    input  wire switch_hdr_pkg::word_t [`SW_NUM_PORTS-1:0]     priority_decoder_in,
    input  wire [`SW_NUM_PORTS-1:0]                            ready,
    input  wire [`SW_NUM_PORTS-1:0]                            eop,
    input  wire switch_arb_pkg::port_idx_t                     select,
    output switch_hdr_pkg::prio_t [`SW_NUM_PORTS-1:0]          priority_out,
    output switch_hdr_pkg::prio_t [`SW_NUM_PORTS-1:0]          pre_priority_out,
    output switch_hdr_pkg::dest_t [`SW_NUM_PORTS-1:0]          des_port_out,
    output logic [`SW_NUM_PORTS-1:0]                           req_mask,
    output logic                                               snap_valid
);

    switch_hdr_pkg::prio_t [`SW_NUM_PORTS-1:0] live_prio;
    switch_hdr_pkg::dest_t [`SW_NUM_PORTS-1:0] live_dest;
    logic capture;
    logic release_snap;

    always_comb begin
        for (int i = 0; i < `SW_NUM_PORTS; i++) begin
            live_prio[i] = switch_hdr_pkg::hdr_prio(priority_decoder_in[i]);
            live_dest[i] = switch_hdr_pkg::hdr_dest(priority_decoder_in[i]);
        end
    end

    assign pre_priority_out = live_prio; // Unregistered view.

    assign capture      = (|ready) && !snap_valid;
    assign release_snap = snap_valid && eop[select];

    always_ff @(posedge clk) begin
        if (rst) begin
            snap_valid   <= 1'b0;
            priority_out <= '0;
        end else if (capture) begin
            snap_valid   <= 1'b1;
            priority_out <= live_prio;
        end else if (release_snap) begin
            snap_valid   <= 1'b0;
            priority_out <= '0; // Zero between packets.
        end
    end

    // Destinations and mask only change on capture.
    always_ff @(posedge clk) begin
        if (capture) begin
            des_port_out <= live_dest;
            req_mask     <= ready;
        end
    end

    // A held snapshot always has at least one requester.
    a_mask_nonzero: assert property (
        @(posedge clk) disable iff (rst) snap_valid |-> (|req_mask)
    ) else $error("priority_decoder: empty request mask while holding");

endmodule

`default_nettype wire

// ==== rtl/switch_arb_pkg.sv ====
`default_nettype none

`include "switch_cfg.svh"

package switch_arb_pkg;

    typedef logic [`SW_DEST_WIDTH-1:0] port_idx_t;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_PICK,
        ARB_GRANT
    } arb_state_t;

    // Round-robin successor that wraps at the port count.
    function automatic port_idx_t rr_next(input port_idx_t p);
        return port_idx_t'(p + 1'b1);
    endfunction

endpackage

`default_nettype wire

// ==== rtl/switch_arbiter_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "switch_cfg.svh"

module switch_arbiter_top (
    input  wire                                            clk,
    input  wire                                            rst,
    input  wire switch_hdr_pkg::word_t [`SW_NUM_PORTS-1:0] data_in,
    input  wire [`SW_NUM_PORTS-1:0]                        ready,
    input  wire [`SW_NUM_PORTS-1:0]                        eop,
    output switch_hdr_pkg::word_t                          out_data,
    output logic                                           out_valid,
    output logic                                           out_last,
    output switch_hdr_pkg::dest_t                          out_dest,
    output switch_hdr_pkg::prio_t [`SW_NUM_PORTS-1:0]      pre_priority_out,
    output switch_hdr_pkg::prio_t [`SW_NUM_PORTS-1:0]      priority_out,
    output switch_arb_pkg::port_idx_t                      select,
    output logic                                           grant_valid
);

    switch_hdr_pkg::dest_t [`SW_NUM_PORTS-1:0] des_port_out;
    logic [`SW_NUM_PORTS-1:0]                  req_mask;
    logic                                      snap_valid;

    // Header fields come from the same bus as the data.
    priority_decoder u_decoder (
        .clk                 (clk),
        .rst                 (rst),
        .priority_decoder_in (data_in),
        .ready               (ready),
        .eop                 (eop),
        .select              (select),
        .priority_out        (priority_out),
        .pre_priority_out    (pre_priority_out),
        .des_port_out        (des_port_out),
        .req_mask            (req_mask),
        .snap_valid          (snap_valid)
    );

    priority_arbiter u_arbiter (
        .clk          (clk),
        .rst          (rst),
        .priority_out (priority_out),
        .req_mask     (req_mask),
        .snap_valid   (snap_valid),
        .select       (select),
        .grant_valid  (grant_valid)
    );

    packet_forwarder u_forwarder (
        .clk          (clk),
        .rst          (rst),
        .data_in      (data_in),
        .ready        (ready),
        .eop          (eop),
        .select       (select),
        .grant_valid  (grant_valid),
        .des_port_out (des_port_out),
        .out_data     (out_data),
        .out_valid    (out_valid),
        .out_last     (out_last),
        .out_dest     (out_dest)
    );

endmodule

`default_nettype wire

// ==== rtl/switch_cfg.svh ====
`ifndef SWITCH_CFG_SVH
`define SWITCH_CFG_SVH

// Switch geometry.
`define SW_NUM_PORTS  16
`define SW_DATA_WIDTH 64

// Header field layout.
`define SW_PRIO_WIDTH 3
`define SW_DEST_WIDTH 4 // Also the width of a port index.
`define SW_PRIO_LSB   4
`define SW_DEST_LSB   0

`endif

// ==== rtl/switch_hdr_pkg.sv ====
`default_nettype none

`include "switch_cfg.svh"

package switch_hdr_pkg;

    typedef logic [`SW_PRIO_WIDTH-1:0] prio_t;
    typedef logic [`SW_DEST_WIDTH-1:0] dest_t;
    typedef logic [`SW_DATA_WIDTH-1:0] word_t;

    // Field extraction from a header word.
    function automatic prio_t hdr_prio(input word_t w);
        return w[`SW_PRIO_LSB +: `SW_PRIO_WIDTH];
    endfunction

    function automatic dest_t hdr_dest(input word_t w);
        return w[`SW_DEST_LSB +: `SW_DEST_WIDTH];
    endfunction

endpackage

`default_nettype wire

// ==== verif/tb_switch_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "switch_cfg.svh"

module tb_switch_arbiter;

    localparam int NUM_TRIALS    = 300;
    localparam int GRANT_TIMEOUT = 16;
    localparam int PKT_TIMEOUT   = 200;
    localparam int LAST_TIMEOUT  = 16;

    logic clk;
    logic rst;
    switch_hdr_pkg::word_t [`SW_NUM_PORTS-1:0] data_in;
    logic [`SW_NUM_PORTS-1:0]                  ready;
    logic [`SW_NUM_PORTS-1:0]                  eop;
    switch_hdr_pkg::word_t                     out_data;
    logic                                      out_valid;
    logic                                      out_last;
    switch_hdr_pkg::dest_t                     out_dest;
    switch_hdr_pkg::prio_t [`SW_NUM_PORTS-1:0] pre_priority_out;
    switch_hdr_pkg::prio_t [`SW_NUM_PORTS-1:0] priority_out;
    switch_arb_pkg::port_idx_t                 select;
    logic                                      grant_valid;

    integer seed;

    // Reference model state.
    switch_hdr_pkg::prio_t     cap_prio [`SW_NUM_PORTS];
    switch_hdr_pkg::dest_t     cap_dest [`SW_NUM_PORTS];
    logic [`SW_NUM_PORTS-1:0]  cap_mask;
    switch_arb_pkg::port_idx_t rr_ptr;
    switch_arb_pkg::port_idx_t winner;
    logic                      exp_valid; // Beat driven on the previous falling edge.
    logic                      exp_last;
    switch_hdr_pkg::word_t     exp_word;

    switch_arbiter_top dut (
        .clk              (clk),
        .rst              (rst),
        .data_in          (data_in),
        .ready            (ready),
        .eop              (eop),
        .out_data         (out_data),
        .out_valid        (out_valid),
        .out_last         (out_last),
        .out_dest         (out_dest),
        .pre_priority_out (pre_priority_out),
        .priority_out     (priority_out),
        .select           (select),
        .grant_valid      (grant_valid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic report_failure();
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timeout at time %0t: %s", $time, what);
        report_failure();
    endtask

    task automatic check_port(input switch_arb_pkg::port_idx_t got,
                              input switch_arb_pkg::port_idx_t exp, input string what);
        if (got !== exp) begin
            $display("Error at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
            report_failure();
        end
    endtask

    task automatic check_prio(input switch_hdr_pkg::prio_t got,
                              input switch_hdr_pkg::prio_t exp, input string what);
        if (got !== exp) begin
            $display("Error at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
            report_failure();
        end
    endtask

    task automatic check_dest(input switch_hdr_pkg::dest_t got,
                              input switch_hdr_pkg::dest_t exp, input string what);
        if (got !== exp) begin
            $display("Error at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
            report_failure();
        end
    endtask

    task automatic check_word(input switch_hdr_pkg::word_t got,
                              input switch_hdr_pkg::word_t exp, input string what);
        if (got !== exp) begin
            $display("Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
            report_failure();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Error at time %0t: %s is %b, expected %b", $time, what, got, exp);
            report_failure();
        end
    endtask

    function automatic switch_hdr_pkg::word_t random_word();
        return {$random(seed), $random(seed)};
    endfunction

    task automatic drive_random_words();
        int i;
        for (i = 0; i < `SW_NUM_PORTS; i++) begin
            data_in[i] = random_word();
        end
    endtask

    // Live priorities follow the words currently on the bus.
    task automatic check_live_prio();
        int i;
        for (i = 0; i < `SW_NUM_PORTS; i++) begin
            check_prio(pre_priority_out[i], data_in[i][`SW_PRIO_LSB +: `SW_PRIO_WIDTH],
                       $sformatf("pre_priority_out[%0d]", i));
        end
    endtask

    task automatic check_snapshot();
        int i;
        for (i = 0; i < `SW_NUM_PORTS; i++) begin
            check_prio(priority_out[i], cap_prio[i], $sformatf("priority_out[%0d]", i));
        end
    endtask

    task automatic check_cleared();
        int i;
        for (i = 0; i < `SW_NUM_PORTS; i++) begin
            check_prio(priority_out[i], '0, $sformatf("priority_out[%0d] after eop", i));
        end
        check_flag(grant_valid, 1'b0, "grant_valid after eop");
    endtask

    task automatic check_output();
        check_flag(out_valid, exp_valid, "out_valid");
        if (exp_valid) begin
            check_word(out_data, exp_word, "out_data");
            check_flag(out_last, exp_last, "out_last");
            check_dest(out_dest, cap_dest[winner], "out_dest");
        end else begin
            check_flag(out_last, 1'b0, "out_last");
        end
    endtask

    // Highest captured priority wins and ties go by round-robin order.
    function automatic switch_arb_pkg::port_idx_t model_winner();
        int k;
        int idx;
        logic found;
        switch_arb_pkg::port_idx_t best;
        switch_hdr_pkg::prio_t     best_prio;
        found     = 1'b0;
        best      = rr_ptr;
        best_prio = '0;
        for (k = 0; k < `SW_NUM_PORTS; k++) begin
            idx = (int'(rr_ptr) + k) % `SW_NUM_PORTS;
            if (cap_mask[idx] && (!found || cap_prio[idx] > best_prio)) begin
                best      = switch_arb_pkg::port_idx_t'(idx);
                best_prio = cap_prio[idx];
                found     = 1'b1;
            end
        end
        return best;
    endfunction

    task automatic run_trial();
        int i;
        int len;
        int sent;
        int cycles;
        logic w_ready;
        logic [31:0] rnd;

        // Headers and a non-empty ready set for the capture.
        @(negedge clk);
        check_output();
        check_live_prio();
        drive_random_words();
        do begin
            rnd = $random(seed);
        end while (rnd[`SW_NUM_PORTS-1:0] == '0);
        cap_mask = rnd[`SW_NUM_PORTS-1:0];
        ready    = cap_mask;
        eop      = '0;
        for (i = 0; i < `SW_NUM_PORTS; i++) begin
            cap_prio[i] = data_in[i][`SW_PRIO_LSB +: `SW_PRIO_WIDTH];
            cap_dest[i] = data_in[i][`SW_DEST_LSB +: `SW_DEST_WIDTH];
        end
        winner    = model_winner();
        exp_valid = 1'b0;

        // Headers keep changing while the snapshot is held.
        cycles = 0;
        @(negedge clk);
        while (!grant_valid) begin
            check_output();
            check_live_prio();
            check_snapshot();
            cycles++;
            if (cycles > GRANT_TIMEOUT) begin
                abort_on_timeout("grant_valid never rose after capture");
            end
            ready = '0;
            drive_random_words();
            @(negedge clk);
        end
        check_port(select, winner, "select");

        rnd    = $random(seed);
        len    = 1 + (rnd % 8);
        sent   = 0;
        cycles = 0;
        while (sent < len) begin
            check_output();
            check_live_prio();
            check_snapshot();
            check_flag(grant_valid, 1'b1, "grant_valid during packet");
            check_port(select, winner, "select during packet");
            cycles++;
            if (cycles > PKT_TIMEOUT) begin
                abort_on_timeout("packet did not complete");
            end
            rnd     = $random(seed);
            w_ready = (rnd[1:0] != 2'b00); // Roughly one gap in four.
            drive_random_words();
            rnd            = $random(seed);
            ready          = rnd[`SW_NUM_PORTS-1:0];
            ready[winner]  = w_ready;
            rnd            = $random(seed);
            eop            = rnd[`SW_NUM_PORTS-1:0];
            eop[winner]    = w_ready && (sent == len - 1);
            exp_valid      = w_ready;
            exp_word       = data_in[winner];
            exp_last       = eop[winner];
            if (w_ready) begin
                sent++;
            end
            @(negedge clk);
        end

        cycles = 0;
        while (!out_last) begin
            cycles++;
            if (cycles > LAST_TIMEOUT) begin
                abort_on_timeout("out_last never seen for the eop word");
            end
            ready = '0;
            eop   = '0;
            @(negedge clk);
        end
        check_output();
        check_cleared();
        ready     = '0;
        eop       = '0;
        exp_valid = 1'b0;
        rr_ptr    = switch_arb_pkg::port_idx_t'((int'(winner) + 1) % `SW_NUM_PORTS);
    endtask

    initial begin
        seed      = 32'hfefd_7cec;
        rst       = 1'b1;
        data_in   = '0;
        ready     = '0;
        eop       = '0;
        rr_ptr    = '0;
        winner    = '0;
        cap_mask  = '0;
        exp_valid = 1'b0;
        exp_last  = 1'b0;
        exp_word  = '0;
        repeat (16) @(negedge clk);
        rst = 1'b0;

        for (int t = 0; t < NUM_TRIALS; t++) begin
            run_trial();
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire
